// File: design/gpio_settings.svh
// GPIO peripheral settings
// Bus widths, register region sizes, identification and output reset values
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// Bus geometry
`define GPIO_DATA_W         32
`define GPIO_ADDR_W         8

// Register regions, eight words in total
`define GPIO_NUM_COMMON     4
`define GPIO_NUM_IN         2
`define GPIO_NUM_OUT        2

// Identification, read back together as {version, id}
`define GPIO_VERSION        16'h0102
`define GPIO_ID             16'h6a10

// Pad state out of reset, all pads undriven
`define GPIO_OUT_DATA_RST   32'h0000_a5a5
`define GPIO_OUT_OE_RST     32'h0000_0000

`endif

// File: design/avmm_bus_pkg.sv
// Avalon-MM bus side types for the GPIO slave
`default_nettype none

`include "gpio_settings.svh"

package avmm_bus_pkg;

    localparam int DATA_W = `GPIO_DATA_W;
    localparam int ADDR_W = `GPIO_ADDR_W;
    // One enable per byte lane
    localparam int BE_W   = DATA_W / 8;

    typedef logic [DATA_W-1:0] bus_word_t;
    typedef logic [ADDR_W-1:0] bus_addr_t;
    typedef logic [BE_W-1:0]   bus_be_t;

    // Avalon response encoding, subset used by this slave
    typedef enum logic [1:0] {
        RESP_OKAY        = 2'b00,
        RESP_SLAVE_ERROR = 2'b10
    } bus_resp_t;

endpackage

`default_nettype wire

// File: design/gpio_map_pkg.sv
// GPIO register map
// Word indices of each region and the board strap layout
`default_nettype none

`include "gpio_settings.svh"

package gpio_map_pkg;

    localparam int NUM_REGS  = `GPIO_NUM_COMMON + `GPIO_NUM_IN + `GPIO_NUM_OUT;
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Common registers
    localparam reg_idx_t REG_VERSION_ID   = reg_idx_t'(0);
    localparam reg_idx_t REG_NUM_REGS     = reg_idx_t'(1);
    localparam reg_idx_t REG_DEVICE_STATE = reg_idx_t'(2);
    localparam reg_idx_t REG_SCRATCH      = reg_idx_t'(3);

    // Input region follows the common block, outputs come last
    localparam reg_idx_t REG_IN_PINS   = reg_idx_t'(`GPIO_NUM_COMMON);
    localparam reg_idx_t REG_IN_STRAPS = reg_idx_t'(`GPIO_NUM_COMMON + 1);
    localparam reg_idx_t REG_OUT_DATA  = reg_idx_t'(`GPIO_NUM_COMMON + `GPIO_NUM_IN);
    localparam reg_idx_t REG_OUT_OE    = reg_idx_t'(`GPIO_NUM_COMMON + `GPIO_NUM_IN + 1);

    // Board straps, zero-extended in the straps register
    typedef struct packed {
        logic [3:0] board_rev;
        logic [1:0] boot_mode;
    } strap_t;

endpackage

`default_nettype wire

// File: design/gpio_in_sync.sv
// Input synchronizer
// Two flop stages bring an asynchronous packed payload into the clock domain
`timescale 1ns/1ns
`default_nettype none

module gpio_in_sync #(
    parameter type payload_t = avmm_bus_pkg::bus_word_t
) (
    input  wire logic     clk_ifc,
    input  wire logic     rst_n,
    input  wire payload_t async_in,
    output payload_t      sync_out
);

    //////////////////////////////////////////////////
    // Synchronizer chain

    // First stage may go metastable, never used directly
    payload_t meta_q;
    payload_t stable_q;

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            meta_q   <= '0;
            stable_q <= '0;
        end else begin
            meta_q   <= async_in;
            stable_q <= meta_q;
        end
    end

    //////////////////////////////////////////////////
    // Output

    assign sync_out = stable_q;

endmodule

`default_nettype wire

// File: design/avmm_gpio_regs.sv
// GPIO register file with Avalon-MM slave
// Decodes word accesses, applies byte lanes and strobes output updates
`timescale 1ns/1ns
`default_nettype none

`include "gpio_settings.svh"

module avmm_gpio_regs (
    input  wire logic                      clk_ifc,
    input  wire logic                      rst_n,

    // Avalon-MM slave
    input  wire avmm_bus_pkg::bus_addr_t   address,
    input  wire logic                      read,
    input  wire logic                      write,
    input  wire avmm_bus_pkg::bus_word_t   writedata,
    input  wire avmm_bus_pkg::bus_be_t     byteenable,
    output avmm_bus_pkg::bus_word_t        readdata,
    output logic                           readdatavalid,
    output avmm_bus_pkg::bus_resp_t        response,
    output logic                           writeresponsevalid,

    // Input register sources, already synchronized
    input  wire avmm_bus_pkg::bus_word_t   in_pins,
    input  wire gpio_map_pkg::strap_t      in_straps,

    // Output registers toward the pin controller
    output avmm_bus_pkg::bus_word_t        out_data,
    output avmm_bus_pkg::bus_word_t        out_oe,
    output logic                           gpout_stb
);

    import avmm_bus_pkg::*;
    import gpio_map_pkg::*;

    //////////////////////////////////////////////////
    // Declarations

    localparam int BYTE_OFS_W = $clog2(BE_W);

    reg_idx_t  word_idx;
    logic      addr_legal;
    logic      idx_output;
    bus_word_t rd_word;

    bus_word_t scratch_q;
    bus_word_t out_data_q;
    bus_word_t out_oe_q;
    bus_word_t in_pins_q;
    strap_t    in_straps_q;
    logic      device_up_q;

    // Replace only the byte lanes that are enabled
    function automatic bus_word_t lane_merge(
        input bus_word_t old_word,
        input bus_word_t new_word,
        input bus_be_t   be
    );
        bus_word_t merged;
        merged = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    //////////////////////////////////////////////////
    // Address decode

    assign word_idx   = reg_idx_t'(address >> BYTE_OFS_W);
    // Word aligned and inside the eight-word map
    assign addr_legal = (address[BYTE_OFS_W-1:0] == '0) &&
                        ((address >> BYTE_OFS_W) < NUM_REGS);
    assign idx_output = (word_idx == REG_OUT_DATA) || (word_idx == REG_OUT_OE);

    // Read mux, every legal word is readable
    always_comb begin
        case (word_idx)
            REG_VERSION_ID:   rd_word = {`GPIO_VERSION, `GPIO_ID};
            REG_NUM_REGS:     rd_word = bus_word_t'(NUM_REGS);
            REG_DEVICE_STATE: rd_word = bus_word_t'(device_up_q);
            REG_SCRATCH:      rd_word = scratch_q;
            REG_IN_PINS:      rd_word = in_pins_q;
            REG_IN_STRAPS:    rd_word = bus_word_t'(in_straps_q);
            REG_OUT_DATA:     rd_word = out_data_q;
            REG_OUT_OE:       rd_word = out_oe_q;
            default:          rd_word = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Register file

    // Writable words, read-only ones accept writes and keep their value
    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            scratch_q  <= '0;
            out_data_q <= `GPIO_OUT_DATA_RST;
            out_oe_q   <= `GPIO_OUT_OE_RST;
        end else if (write && addr_legal) begin
            case (word_idx)
                REG_SCRATCH:  scratch_q  <= lane_merge(scratch_q, writedata, byteenable);
                REG_OUT_DATA: out_data_q <= lane_merge(out_data_q, writedata, byteenable);
                REG_OUT_OE:   out_oe_q   <= lane_merge(out_oe_q, writedata, byteenable);
                default: ;
            endcase
        end
    end

    // Input words reload every cycle
    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            in_pins_q   <= '0;
            in_straps_q <= '0;
        end else begin
            in_pins_q   <= in_pins;
            in_straps_q <= in_straps;
        end
    end

    // Device reports up from the first clock out of reset
    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            device_up_q <= 1'b0;
        end else begin
            device_up_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Responses and update strobe

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            readdata           <= '0;
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            response           <= RESP_OKAY;
            gpout_stb          <= 1'b0;
        end else begin
            readdatavalid      <= read;
            writeresponsevalid <= write;
            // Illegal reads return zero data
            readdata           <= (read && addr_legal) ? rd_word : '0;
            if ((read || write) && !addr_legal) begin
                response <= RESP_SLAVE_ERROR;
            end else begin
                response <= RESP_OKAY;
            end
            gpout_stb          <= write && addr_legal && idx_output;
        end
    end

    assign out_data = out_data_q;
    assign out_oe   = out_oe_q;

endmodule

`default_nettype wire

// File: design/gpio_pin_ctrl.sv
// GPIO pin controller
// Applies output registers to the pads on strobe and builds the pin view
`timescale 1ns/1ns
`default_nettype none

`include "gpio_settings.svh"

module gpio_pin_ctrl (
    input  wire logic                    clk_ifc,
    input  wire logic                    rst_n,

    // From the register block
    input  wire avmm_bus_pkg::bus_word_t out_data,
    input  wire avmm_bus_pkg::bus_word_t out_oe,
    input  wire logic                    gpout_stb,

    // Synchronized pad levels
    input  wire avmm_bus_pkg::bus_word_t pad_in_sync,

    // Pad side and the merged input view
    output avmm_bus_pkg::bus_word_t      pad_out,
    output avmm_bus_pkg::bus_word_t      pad_oe,
    output avmm_bus_pkg::bus_word_t      pin_view
);

    //////////////////////////////////////////////////
    // Pad latches

    // Pads change only on the strobe, so data and direction
    // written as separate words land together
    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            pad_out <= `GPIO_OUT_DATA_RST;
            pad_oe  <= `GPIO_OUT_OE_RST;
        end else if (gpout_stb) begin
            pad_out <= out_data;
            pad_oe  <= out_oe;
        end
    end

    //////////////////////////////////////////////////
    // Input view

    // Driven bits reflect what we drive, the rest come from the pad
    assign pin_view = (pad_oe & pad_out) | (~pad_oe & pad_in_sync);

endmodule

`default_nettype wire

// File: design/gpio_subsystem_top.sv
// GPIO subsystem top level
// Input synchronizers, register block and pin controller
`timescale 1ns/1ns
`default_nettype none

module gpio_subsystem_top (
    input  wire logic                    clk_ifc,
    input  wire logic                    rst_n,

    // Avalon-MM slave
    input  wire avmm_bus_pkg::bus_addr_t address,
    input  wire logic                    read,
    input  wire logic                    write,
    input  wire avmm_bus_pkg::bus_word_t writedata,
    input  wire avmm_bus_pkg::bus_be_t   byteenable,
    output avmm_bus_pkg::bus_word_t      readdata,
    output logic                         readdatavalid,
    output avmm_bus_pkg::bus_resp_t      response,
    output logic                         writeresponsevalid,

    // Pads and straps, inputs asynchronous
    input  wire avmm_bus_pkg::bus_word_t pad_in,
    input  wire gpio_map_pkg::strap_t    board_straps,
    output avmm_bus_pkg::bus_word_t      pad_out,
    output avmm_bus_pkg::bus_word_t      pad_oe
);

    import avmm_bus_pkg::*;
    import gpio_map_pkg::*;

    bus_word_t pad_in_sync;
    strap_t    straps_sync;
    bus_word_t pin_view;
    bus_word_t out_data;
    bus_word_t out_oe;
    logic      gpout_stb;

    //////////////////////////////////////////////////
    // Input synchronizers

    gpio_in_sync #(
        .payload_t (bus_word_t)
    ) u_pin_sync (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .async_in (pad_in),
        .sync_out (pad_in_sync)
    );

    gpio_in_sync #(
        .payload_t (strap_t)
    ) u_strap_sync (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .async_in (board_straps),
        .sync_out (straps_sync)
    );

    //////////////////////////////////////////////////
    // Register block and pin controller

    avmm_gpio_regs u_regs (
        .clk_ifc            (clk_ifc),
        .rst_n              (rst_n),
        .address            (address),
        .read               (read),
        .write              (write),
        .writedata          (writedata),
        .byteenable         (byteenable),
        .readdata           (readdata),
        .readdatavalid      (readdatavalid),
        .response           (response),
        .writeresponsevalid (writeresponsevalid),
        .in_pins            (pin_view),
        .in_straps          (straps_sync),
        .out_data           (out_data),
        .out_oe             (out_oe),
        .gpout_stb          (gpout_stb)
    );

    gpio_pin_ctrl u_pin_ctrl (
        .clk_ifc     (clk_ifc),
        .rst_n       (rst_n),
        .out_data    (out_data),
        .out_oe      (out_oe),
        .gpout_stb   (gpout_stb),
        .pad_in_sync (pad_in_sync),
        .pad_out     (pad_out),
        .pad_oe      (pad_oe),
        .pin_view    (pin_view)
    );

endmodule

`default_nettype wire

// File: verification/gpio_properties.sv
// GPIO bus and pad timing properties
// Bound into the subsystem top, checks responses, update strobe and pad latching
`timescale 1ns/1ns
`default_nettype none

module gpio_properties (
    input  wire logic                    clk_ifc,
    input  wire logic                    rst_n,
    input  wire avmm_bus_pkg::bus_addr_t address,
    input  wire logic                    read,
    input  wire logic                    write,
    input  wire logic                    readdatavalid,
    input  wire avmm_bus_pkg::bus_resp_t response,
    input  wire logic                    writeresponsevalid,
    input  wire avmm_bus_pkg::bus_word_t out_data,
    input  wire avmm_bus_pkg::bus_word_t out_oe,
    input  wire logic                    gpout_stb,
    input  wire avmm_bus_pkg::bus_word_t pad_out,
    input  wire avmm_bus_pkg::bus_word_t pad_oe
);

    import avmm_bus_pkg::*;
    import gpio_map_pkg::*;

    int unsigned fail_count = 0;

    reg_idx_t  idx;
    logic      legal;
    logic      read_q;
    logic      write_q;
    logic      out_wr_q;
    logic      stb_q;
    bus_resp_t resp_q;
    bus_word_t out_data_q;
    bus_word_t out_oe_q;

    assign idx   = reg_idx_t'(address >> 2);
    assign legal = (address[1:0] == 2'b00) && (address < bus_addr_t'(4 * NUM_REGS));

    // Bus inputs one edge back, lined up with the registered outputs
    always_ff @(posedge clk_ifc) begin
        read_q     <= read;
        write_q    <= write;
        out_wr_q   <= write && legal && (idx == REG_OUT_DATA || idx == REG_OUT_OE);
        stb_q      <= gpout_stb;
        resp_q     <= legal ? RESP_OKAY : RESP_SLAVE_ERROR;
        out_data_q <= out_data;
        out_oe_q   <= out_oe;
    end

    //////////////////////////////////////////////////
    // Response timing

    a_read_valid: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        readdatavalid == read_q) else begin
        fail_count++;
        $error("Mismatch at %0t: readdatavalid is %0b, expected %0b",
               $time, $sampled(readdatavalid), $sampled(read_q));
    end

    a_write_valid: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        writeresponsevalid == write_q) else begin
        fail_count++;
        $error("Mismatch at %0t: writeresponsevalid is %0b, expected %0b",
               $time, $sampled(writeresponsevalid), $sampled(write_q));
    end

    a_response: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        (read_q || write_q) |-> response == resp_q) else begin
        fail_count++;
        $error("Mismatch at %0t: response is %0d, expected %0d",
               $time, $sampled(response), $sampled(resp_q));
    end

    //////////////////////////////////////////////////
    // Output update

    a_update_stb: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        gpout_stb == out_wr_q) else begin
        fail_count++;
        $error("Mismatch at %0t: gpout_stb is %0b, expected %0b",
               $time, $sampled(gpout_stb), $sampled(out_wr_q));
    end

    // Pads take the registers on the edge after the strobe
    a_pad_latch: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        stb_q |-> (pad_out == out_data_q) && (pad_oe == out_oe_q)) else begin
        fail_count++;
        $error("Mismatch at %0t: pad_out is %h, expected %h, pad_oe is %h, expected %h",
               $time, $sampled(pad_out), $sampled(out_data_q),
               $sampled(pad_oe), $sampled(out_oe_q));
    end

endmodule

`default_nettype wire

// File: verification/gpio_tb.sv
// GPIO subsystem testbench
// Directed and random bus traffic against a shadow model, then pad and strap changes
`timescale 1ns/1ns
`default_nettype none

`include "gpio_settings.svh"

module gpio_tb;

    import avmm_bus_pkg::*;
    import gpio_map_pkg::*;

    // Roughly 860 cycles of traffic, limit leaves a wide margin
    localparam int CYCLE_LIMIT = 2000;
    localparam int MAP_BYTES   = 4 * (`GPIO_NUM_COMMON + `GPIO_NUM_IN + `GPIO_NUM_OUT);

    logic      clk_ifc;
    logic      rst_n;
    bus_addr_t address;
    logic      read;
    logic      write;
    bus_word_t writedata;
    bus_be_t   byteenable;
    bus_word_t readdata;
    logic      readdatavalid;
    bus_resp_t response;
    logic      writeresponsevalid;
    bus_word_t pad_in;
    strap_t    board_straps;
    bus_word_t pad_out;
    bus_word_t pad_oe;

    // Shadow of the writable registers
    bus_word_t scratch_sh;
    bus_word_t out_data_sh;
    bus_word_t out_oe_sh;

    int unsigned check_errors = 0;
    int unsigned cycle_count  = 0;

    gpio_subsystem_top dut (
        .clk_ifc (clk_ifc), .rst_n (rst_n), .address (address), .read (read),
        .write (write), .writedata (writedata), .byteenable (byteenable),
        .readdata (readdata), .readdatavalid (readdatavalid), .response (response),
        .writeresponsevalid (writeresponsevalid), .pad_in (pad_in),
        .board_straps (board_straps), .pad_out (pad_out), .pad_oe (pad_oe)
    );

    bind gpio_subsystem_top gpio_properties u_props (
        .clk_ifc (clk_ifc), .rst_n (rst_n), .address (address), .read (read),
        .write (write), .readdatavalid (readdatavalid), .response (response),
        .writeresponsevalid (writeresponsevalid), .out_data (out_data),
        .out_oe (out_oe), .gpout_stb (gpout_stb), .pad_out (pad_out), .pad_oe (pad_oe)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #2 clk_ifc = ~clk_ifc;
    end

    always @(posedge clk_ifc) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference rules

    // Word aligned and inside the eight-word map
    function automatic logic legal_address(input bus_addr_t addr);
        return (addr[1:0] == 2'b00) && (addr < bus_addr_t'(MAP_BYTES));
    endfunction

    function automatic bus_word_t merge_bytes(
        input bus_word_t old_word,
        input bus_word_t wr_word,
        input bus_be_t   be
    );
        bus_word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                result[8*b +: 8] = wr_word[8*b +: 8];
        end
        return result;
    endfunction

    // Expected word for a legal read
    function automatic bus_word_t model_read(input reg_idx_t idx);
        case (idx)
            REG_VERSION_ID:   return {`GPIO_VERSION, `GPIO_ID};
            REG_NUM_REGS:     return 32'd8;
            REG_DEVICE_STATE: return 32'd1;
            REG_SCRATCH:      return scratch_sh;
            REG_IN_PINS:      return (out_oe_sh & out_data_sh) | (~out_oe_sh & pad_in);
            REG_IN_STRAPS:    return bus_word_t'(board_straps);
            REG_OUT_DATA:     return out_data_sh;
            default:          return out_oe_sh;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Bus tasks

    task automatic expect_equal(input string name, input bus_word_t got, input bus_word_t exp);
        assert (got === exp) else begin
            check_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_ifc);
    endtask

    task automatic read_word(input bus_addr_t addr, output bus_word_t data,
                             output bus_resp_t resp);
        @(negedge clk_ifc);
        address = addr;
        read    = 1'b1;
        @(negedge clk_ifc);
        read = 1'b0;
        while (!readdatavalid)
            @(negedge clk_ifc);
        data = readdata;
        resp = response;
    endtask

    task automatic write_word(input bus_addr_t addr, input bus_word_t data,
                              input bus_be_t be, output bus_resp_t resp);
        @(negedge clk_ifc);
        address    = addr;
        writedata  = data;
        byteenable = be;
        write      = 1'b1;
        @(negedge clk_ifc);
        write = 1'b0;
        while (!writeresponsevalid)
            @(negedge clk_ifc);
        resp = response;
    endtask

    // One access, checked against the shadow model
    task automatic run_access(input logic is_write, input bus_addr_t addr,
                              input bus_word_t data, input bus_be_t be);
        bus_word_t got;
        bus_resp_t resp;
        reg_idx_t  idx;
        logic      ok;
        idx = reg_idx_t'(addr >> 2);
        ok  = legal_address(addr);
        if (is_write) begin
            write_word(addr, data, be, resp);
            if (ok && idx == REG_SCRATCH)
                scratch_sh = merge_bytes(scratch_sh, data, be);
            if (ok && idx == REG_OUT_DATA)
                out_data_sh = merge_bytes(out_data_sh, data, be);
            if (ok && idx == REG_OUT_OE)
                out_oe_sh = merge_bytes(out_oe_sh, data, be);
            if (ok && (idx == REG_OUT_DATA || idx == REG_OUT_OE)) begin
                // Pads follow on the edge after the strobe
                while (dut.gpout_stb)
                    @(negedge clk_ifc);
                expect_equal("pad_out", pad_out, out_data_sh);
                expect_equal("pad_oe", pad_oe, out_oe_sh);
            end
        end else begin
            read_word(addr, got, resp);
            expect_equal("readdata", got, ok ? model_read(idx) : '0);
        end
        expect_equal("response", bus_word_t'(resp),
                     ok ? bus_word_t'(RESP_OKAY) : bus_word_t'(RESP_SLAVE_ERROR));
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        bus_addr_t addr;
        void'($urandom(32'hc08c_ac77));
        rst_n        = 1'b0;
        address      = '0;
        read         = 1'b0;
        write        = 1'b0;
        writedata    = '0;
        byteenable   = '0;
        pad_in       = '0;
        board_straps = '0;
        scratch_sh   = '0;
        out_data_sh  = `GPIO_OUT_DATA_RST;
        out_oe_sh    = `GPIO_OUT_OE_RST;
        wait_cycles(8);
        rst_n = 1'b1;

        expect_equal("readdatavalid", bus_word_t'(readdatavalid), '0);
        expect_equal("writeresponsevalid", bus_word_t'(writeresponsevalid), '0);
        expect_equal("gpout_stb", bus_word_t'(dut.gpout_stb), '0);
        expect_equal("pad_out", pad_out, `GPIO_OUT_DATA_RST);
        expect_equal("pad_oe", pad_oe, `GPIO_OUT_OE_RST);

        // Directed accesses, common words first
        for (int i = 0; i < 3; i++)
            run_access(1'b0, bus_addr_t'(4 * i), '0, '1);
        run_access(1'b1, 8'h0c, 32'hdead_beef, 4'hf);
        run_access(1'b1, 8'h0c, 32'h1234_5678, 4'b0101);
        run_access(1'b0, 8'h0c, '0, '1);
        // Read-only words take the write and keep their value
        for (int i = 0; i < 6; i++) begin
            if (i != 3)
                run_access(1'b1, bus_addr_t'(4 * i), '1, 4'hf);
        end
        for (int i = 0; i < 6; i++)
            run_access(1'b0, bus_addr_t'(4 * i), '0, '1);
        run_access(1'b1, 8'h0d, 32'h5555_5555, 4'hf);
        run_access(1'b0, 8'h40, '0, '1);
        run_access(1'b1, 8'h18, 32'h0f0f_00ff, 4'b1001);

        // Random traffic, about one address in five illegal
        for (int n = 0; n < 300; n++) begin
            if ($urandom_range(4) == 0) begin
                do
                    addr = bus_addr_t'($urandom);
                while (legal_address(addr));
            end else begin
                addr = bus_addr_t'($urandom_range(7) * 4);
            end
            run_access(1'($urandom_range(1)), addr, $urandom, bus_be_t'($urandom));
        end

        // Pad and strap changes, pads undriven for the first half
        run_access(1'b1, 8'h1c, '0, 4'hf);
        for (int n = 0; n < 20; n++) begin
            if (n == 10)
                run_access(1'b1, 8'h1c, $urandom, 4'hf);
            pad_in       = $urandom;
            board_straps = 6'($urandom_range(63));
            // Two synchronizer stages plus the input register
            wait_cycles(2);
            run_access(1'b0, 8'h10, '0, '1);
            run_access(1'b0, 8'h14, '0, '1);
        end

        wait_cycles(2);
        $display("Errors: %0d checks, %0d assertions", check_errors, dut.u_props.fail_count);
        if (check_errors == 0 && dut.u_props.fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/avmm_bus_pkg.sv
design/gpio_map_pkg.sv
design/gpio_in_sync.sv
design/avmm_gpio_regs.sv
design/gpio_pin_ctrl.sv
design/gpio_subsystem_top.sv
verification/gpio_properties.sv
verification/gpio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the GPIO testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f src.f --top-module gpio_tb -o gpio_sim \
    && ./obj_dir/gpio_sim +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -qxF '*** TEST PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
